/* source/transPkg.sv */
// transactor shared definitions

package transPkg;

   ////////////////////////////////////////
   // bus and size widths
   ////////////////////////////////////////

   // one client word, the unit of every access size
   localparam int wordW = 32;

   // the client data bus carries two words per beat
   // the word at the current index rides in the high half
   localparam int busW = 2 * wordW;

   // total sizes and access sizes count words
   // a value of 0 stands for 64 words
   localparam int sizeW = 6;

   typedef logic [sizeW-1:0] sizeT;

   ////////////////////////////////////////
   // line actions
   ////////////////////////////////////////

   // what the transactor does to the line that is currently open
   //   actRead        client reads part or all of a line
   //   actReadClear   line is read, returned and then written to zero
   //   actFullWrite   client supplies every word of the line
   //   actMergeWrite  line is read, merged with client words and written back
   typedef enum logic [1:0]
   {
      actRead       = 2'd0,
      actReadClear  = 2'd1,
      actFullWrite  = 2'd2,
      actMergeWrite = 2'd3
   } lineActionT;

   // in every line, word i sits at bits [i*wordW +: wordW]

endpackage

/* source/lineIf.sv */
// line state bus
`timescale 1ns/1ps

// state of the open line, from the sequencer to the buffer and the responder
interface lineIf import transPkg::*; ();

   // a line is open and being worked on
   logic       lineValid;
   // action chosen when the line was opened
   lineActionT lineAction;
   // high in the cycle a client request opens a line
   logic       lineNew;
   // memory read data for this line has been captured
   logic       readComplete;
   // memory write for this line has been granted
   logic       writeDone;
   // a client write beat is taken into the buffer this cycle
   logic       writeXfer;

   modport seqMp
   (
      output lineValid, lineAction, lineNew, readComplete, writeDone, writeXfer
   );

   // the buffer only needs to know when to take data and what to write back
   modport bufMp (input lineAction, lineNew, writeXfer);

   modport respMp
   (
      input lineValid, lineAction, lineNew, readComplete, writeDone
   );

endinterface

/* source/lineSequencer.sv */
// line action sequencer
`timescale 1ns/1ps

module lineSequencer import transPkg::*;
#(
   parameter int LineWords = 4,
   parameter int Depth     = 16
) (
   input  logic                                     sysClk,
   input  logic                                     rstN,
   input  logic                                     supRead,
   input  logic                                     supWrite,
   input  logic [$clog2(Depth)+$clog2(LineWords)-1:0] supAddress,
   input  logic [sizeW-1:0]                         supTotalSize,
   input  logic                                     cpuGrant,
   input  logic                                     cpuDataValid,
   input  logic                                     lastReadResponse,
   lineIf.seqMp                                     line,
   output logic                                     cpuReq,
   output logic                                     cpuWrite,
   output logic [$clog2(Depth)-1:0]                 cpuAddress
);

   localparam int idxW  = $clog2(LineWords);
   localparam int addrW = $clog2(Depth);

   logic             lineValidQ;
   lineActionT       actionQ;
   logic             readIssuedQ;
   logic             readCompleteQ;
   logic             dinNeededQ;
   logic             writeDoneQ;
   logic [addrW-1:0] lineAddrQ;

   logic [idxW-1:0]  wordIdx;
   logic             lineNew;
   logic             writeXfer;
   logic             lastPulse;
   logic             fullLine;
   lineActionT       nextAction;
   logic             memRead;
   logic             memWrite;
   logic             lineDone;

   ////////////////////////////////////////
   // request decode
   ////////////////////////////////////////

   assign wordIdx = supAddress[idxW-1:0];

   // only one line is in flight, so a request opens a line whenever none is open
   assign lineNew = ~lineValidQ & (supRead | supWrite);

   // write beats are taken on the opening beat and while data is still owed
   assign writeXfer = supWrite & ~supRead & (lineNew | lineValidQ & dinNeededQ);

   // the client presents the words left from supAddress with every beat
   // so a beat is the last one when it uses up that size or reaches the line end
   assign lastPulse = (supTotalSize == sizeW'(1)) | (supTotalSize == sizeW'(2)) |
                      (&wordIdx[idxW-1:1]);

   // a size of 0 means 64 words, hence the extra top bit
   assign fullLine = (wordIdx == '0) &
                     ({supTotalSize == '0, supTotalSize} >= (sizeW+1)'(LineWords));

   always_comb
   begin
      if (supRead && supWrite)
         nextAction = actReadClear;
      else if (supRead)
         nextAction = actRead;
      else if (fullLine)
         nextAction = actFullWrite;
      else
         nextAction = actMergeWrite;
   end

   ////////////////////////////////////////
   // memory requests
   ////////////////////////////////////////

   // merge writes read only once all client words sit in the buffer
   assign memRead = lineValidQ & ~readIssuedQ &
                    ((actionQ == actRead) | (actionQ == actReadClear) |
                     (actionQ == actMergeWrite) & ~dinNeededQ);

   // read-clear and merge write both write back after the read data is home
   assign memWrite = lineValidQ & ~writeDoneQ &
                     ((actionQ == actFullWrite) & ~dinNeededQ |
                      (actionQ == actReadClear) & readCompleteQ |
                      (actionQ == actMergeWrite) & readCompleteQ);

   assign cpuReq     = memRead | memWrite;
   assign cpuWrite   = memWrite;
   assign cpuAddress = lineAddrQ;

   // reads finish on their last response, writes the cycle after the grant
   assign lineDone = lineValidQ &
                     (((actionQ == actRead) | (actionQ == actReadClear)) ? lastReadResponse
                                                                          : writeDoneQ);

   always_ff @(posedge sysClk)
   begin
      if (!rstN)
      begin
         lineValidQ    <= 1'b0;
         actionQ       <= actRead;
         readIssuedQ   <= 1'b0;
         readCompleteQ <= 1'b0;
         dinNeededQ    <= 1'b0;
         writeDoneQ    <= 1'b0;
      end
      else if (lineNew)
      begin
         lineValidQ    <= 1'b1;
         actionQ       <= nextAction;
         readIssuedQ   <= 1'b0;
         readCompleteQ <= 1'b0;
         writeDoneQ    <= 1'b0;
         dinNeededQ    <= writeXfer & ~lastPulse;
      end
      else
      begin
         if (lineDone)
            lineValidQ <= 1'b0;
         if (memRead && cpuGrant)
            readIssuedQ <= 1'b1;
         if (lineValidQ && cpuDataValid)
            readCompleteQ <= 1'b1;
         if (memWrite && cpuGrant)
            writeDoneQ <= 1'b1;
         if (writeXfer)
            dinNeededQ <= ~lastPulse;
      end
   end

   // the address is kept so the client may move on while the line finishes
   always_ff @(posedge sysClk)
   begin
      if (lineNew)
         lineAddrQ <= supAddress[addrW+idxW-1:idxW];
   end

   assign line.lineValid    = lineValidQ;
   assign line.lineAction   = actionQ;
   assign line.lineNew      = lineNew;
   assign line.readComplete = readCompleteQ;
   assign line.writeDone    = writeDoneQ;
   assign line.writeXfer    = writeXfer;

endmodule

/* source/lineBuffer.sv */
// one-line data buffer
`timescale 1ns/1ps

module lineBuffer import transPkg::*;
#(
   parameter int LineWords = 4,
   parameter int Depth     = 16
) (
   input  logic                                     sysClk,
   input  logic [$clog2(Depth)+$clog2(LineWords)-1:0] supAddress,
   input  logic [sizeW-1:0]                         supTotalSize,
   input  logic [busW-1:0]                          supWriteData,
   input  logic                                     cpuDataValid,
   input  logic [LineWords*wordW-1:0]               cpuReadData,
   lineIf.bufMp                                     line,
   output logic [LineWords*wordW-1:0]               cpuWriteData,
   output logic [LineWords*wordW-1:0]               bufLine
);

   localparam int idxW = $clog2(LineWords);

   logic [LineWords*wordW-1:0] lineQ;
   // words the client has written since the line opened
   logic [LineWords-1:0]       dirtyQ;

   logic [idxW-1:0]            hiIdx;
   logic [idxW-1:0]            loIdx;
   logic                       oneWord;
   logic [LineWords-1:0]       hiSel;
   logic [LineWords-1:0]       loSel;

   ////////////////////////////////////////
   // client write word select
   ////////////////////////////////////////

   assign hiIdx = supAddress[idxW-1:0];
   assign loIdx = hiIdx + 1'b1;

   // the low half is dropped when one word is left or at the last word of the line
   assign oneWord = (supTotalSize == sizeW'(1)) | (hiIdx == idxW'(LineWords - 1));

   always_comb
   begin
      hiSel = '0;
      loSel = '0;
      if (line.writeXfer)
      begin
         hiSel[hiIdx] = 1'b1;
         if (!oneWord)
            loSel[loIdx] = 1'b1;
      end
   end

   ////////////////////////////////////////
   // line storage
   ////////////////////////////////////////

   // client data wins over memory data, and memory data never lands on a
   // dirty word, which is what keeps the client words in a merge write
   always_ff @(posedge sysClk)
   begin
      for (int w = 0; w < LineWords; w++)
      begin
         if (hiSel[w])
            lineQ[w*wordW +: wordW] <= supWriteData[busW-1 -: wordW];
         else if (loSel[w])
            lineQ[w*wordW +: wordW] <= supWriteData[wordW-1:0];
         else if (cpuDataValid && !dirtyQ[w])
            lineQ[w*wordW +: wordW] <= cpuReadData[w*wordW +: wordW];
      end
   end

   // a new line starts clean, apart from what its opening beat writes
   always_ff @(posedge sysClk)
   begin
      dirtyQ <= (line.lineNew ? '0 : dirtyQ) | hiSel | loSel;
   end

   assign bufLine = lineQ;

   // read-clear writes zeros back and keeps the old data for the responses
   assign cpuWriteData = (line.lineAction == actReadClear) ? '0 : lineQ;

endmodule

/* source/supResponder.sv */
// client response generator
`timescale 1ns/1ps

module supResponder import transPkg::*;
#(
   parameter int LineWords = 4,
   parameter int Depth     = 16
) (
   input  logic                                     sysClk,
   input  logic [$clog2(Depth)+$clog2(LineWords)-1:0] supAddress,
   input  logic [sizeW-1:0]                         supTotalSize,
   input  logic [LineWords*wordW-1:0]               bufLine,
   lineIf.respMp                                    line,
   output logic                                     readDataValid,
   output logic [busW-1:0]                          readData,
   output logic [sizeW-1:0]                         accessSize,
   output logic                                     accessComplete,
   output logic                                     lastReadResponse
);

   localparam int idxW = $clog2(LineWords);

   // position in the line and words still owed to the client
   logic [idxW-1:0] idxQ;
   sizeT            remQ;

   logic [idxW-1:0] loIdx;
   logic            oneWord;
   logic            lastFlag;
   sizeT            respSize;
   logic            readType;
   logic            writeType;

   assign loIdx     = idxQ + 1'b1;
   assign readType  = (line.lineAction == actRead) | (line.lineAction == actReadClear);
   assign writeType = ~readType;

   // a response carries two words unless one is left or the index is at the line end
   assign oneWord  = (remQ == sizeT'(1)) | (idxQ == idxW'(LineWords - 1));
   assign respSize = oneWord ? sizeT'(1) : sizeT'(2);
   assign lastFlag = (remQ == sizeT'(1)) | (remQ == sizeT'(2)) | (&idxQ[idxW-1:1]);

   // read-clear keeps its last response back until the zeros are in memory
   assign readDataValid = line.lineValid & readType & line.readComplete &
                          (~lastFlag | (line.lineAction == actRead) | line.writeDone);

   assign lastReadResponse = readDataValid & lastFlag;

   assign readData = {bufLine[idxQ*wordW +: wordW],
                      oneWord ? {wordW{1'b0}} : bufLine[loIdx*wordW +: wordW]};

   // write completions report the line size
   assign accessSize = readDataValid ? respSize : sizeT'(LineWords);

   assign accessComplete = lastReadResponse | line.lineValid & writeType & line.writeDone;

   always_ff @(posedge sysClk)
   begin
      if (line.lineNew)
      begin
         idxQ <= supAddress[idxW-1:0];
         remQ <= supTotalSize;
      end
      else if (readDataValid)
      begin
         idxQ <= idxQ + idxW'(respSize);
         remQ <= remQ - respSize;
      end
   end

endmodule

/* source/cepTransactor.sv */
// register bus to line memory transactor
`timescale 1ns/1ps

module cepTransactor import transPkg::*;
#(
   parameter int LineWords = 4,
   parameter int Depth     = 16
) (
   input  logic                                     sysClk,
   input  logic                                     rstN,

   // client side, address is the line address followed by the word index
   input  logic                                     supRead,
   input  logic                                     supWrite,
   input  logic [$clog2(Depth)+$clog2(LineWords)-1:0] supAddress,
   input  logic [sizeW-1:0]                         supTotalSize,
   input  logic [busW-1:0]                          supWriteData,
   output logic                                     readDataValid,
   output logic [busW-1:0]                          readData,
   output logic [sizeW-1:0]                         accessSize,
   output logic                                     accessComplete,

   // memory side, request signals hold until cpuGrant
   output logic                                     cpuReq,
   output logic                                     cpuWrite,
   output logic [$clog2(Depth)-1:0]                 cpuAddress,
   output logic [LineWords*wordW-1:0]               cpuWriteData,
   input  logic                                     cpuGrant,
   input  logic                                     cpuDataValid,
   input  logic [LineWords*wordW-1:0]               cpuReadData
);

   logic                       lastReadResponse;
   logic [LineWords*wordW-1:0] bufLine;

   lineIf lineBus ();

   lineSequencer #(.LineWords(LineWords), .Depth(Depth)) u_sequencer (
      .sysClk           (sysClk),
      .rstN             (rstN),
      .supRead          (supRead),
      .supWrite         (supWrite),
      .supAddress       (supAddress),
      .supTotalSize     (supTotalSize),
      .cpuGrant         (cpuGrant),
      .cpuDataValid     (cpuDataValid),
      .lastReadResponse (lastReadResponse),
      .line             (lineBus.seqMp),
      .cpuReq           (cpuReq),
      .cpuWrite         (cpuWrite),
      .cpuAddress       (cpuAddress)
   );

   lineBuffer #(.LineWords(LineWords), .Depth(Depth)) u_buffer (
      .sysClk       (sysClk),
      .supAddress   (supAddress),
      .supTotalSize (supTotalSize),
      .supWriteData (supWriteData),
      .cpuDataValid (cpuDataValid),
      .cpuReadData  (cpuReadData),
      .line         (lineBus.bufMp),
      .cpuWriteData (cpuWriteData),
      .bufLine      (bufLine)
   );

   supResponder #(.LineWords(LineWords), .Depth(Depth)) u_responder (
      .sysClk           (sysClk),
      .supAddress       (supAddress),
      .supTotalSize     (supTotalSize),
      .bufLine          (bufLine),
      .line             (lineBus.respMp),
      .readDataValid    (readDataValid),
      .readData         (readData),
      .accessSize       (accessSize),
      .accessComplete   (accessComplete),
      .lastReadResponse (lastReadResponse)
   );

endmodule

/* bench/transactorTb.sv */
// transactor testbench
`timescale 1ns/1ps

module transactorTb import transPkg::*; ();

   localparam int LineWords = 4;
   localparam int Depth     = 16;
   localparam int idxW      = $clog2(LineWords);
   localparam int addrW     = $clog2(Depth);
   localparam int lineW     = LineWords * wordW;
   // longest stretch of cycles any wait may take before it counts as a hang
   localparam int waitLimit = 200;

   logic                  sysClk;
   logic                  rstN;
   logic                  supRead;
   logic                  supWrite;
   logic [addrW+idxW-1:0] supAddress;
   logic [sizeW-1:0]      supTotalSize;
   logic [busW-1:0]       supWriteData;
   logic                  readDataValid;
   logic [busW-1:0]       readData;
   logic [sizeW-1:0]      accessSize;
   logic                  accessComplete;
   logic                  cpuReq;
   logic                  cpuWrite;
   logic [addrW-1:0]      cpuAddress;
   logic [lineW-1:0]      cpuWriteData;
   logic                  cpuGrant;
   logic                  cpuDataValid;
   logic [lineW-1:0]      cpuReadData;

   // contents of the memory model, and the copy the checks expect
   logic [lineW-1:0]      mem [Depth];
   logic [wordW-1:0]      refMem [Depth][LineWords];

   cepTransactor #(.LineWords(LineWords), .Depth(Depth)) u_dut (.*);

   initial
   begin
      sysClk = 1'b0;
      forever #4 sysClk = ~sysClk;
   end

   ////////////////////////////////////////
   // checks and helpers
   ////////////////////////////////////////

   task automatic checkValue(input string name, input logic [lineW-1:0] got,
                             input logic [lineW-1:0] exp);
      if (got !== exp)
      begin
         $display("FAILED %s got %h expected %h", name, got, exp);
         $display("Errors found");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   task automatic reportTimeout(input string what);
      $display("timed out while waiting for %s", what);
      $display("Errors found");
      $fatal(1, "stopping after a timeout");
   endtask

   // mostly short sizes, so that sizes ending inside a line come up often
   function automatic int randomSize();
      if ($urandom_range(1, 0) == 1)
         return $urandom_range(6, 1);
      return $urandom_range(63, 0);
   endfunction

   ////////////////////////////////////////
   // memory model
   ////////////////////////////////////////

   // grants after 0 to 3 cycles, returns read data 1 to 4 cycles after the grant
   // and checks every held cycle of a request for stable request signals
   initial
   begin : memoryModel
      logic             held;
      logic             rdPending;
      int               grantWait;
      int               dataWait;
      logic [addrW-1:0] reqAddr;
      logic [addrW-1:0] rdAddr;
      logic             reqWrite;
      logic [lineW-1:0] reqData;
      cpuGrant     = 1'b0;
      cpuDataValid = 1'b0;
      cpuReadData  = '0;
      held         = 1'b0;
      rdPending    = 1'b0;
      grantWait    = 0;
      dataWait     = 0;
      forever
      begin
         @(negedge sysClk);
         cpuDataValid = 1'b0;
         // the grant driven last time was taken on the rising edge just passed
         if (cpuGrant)
         begin
            cpuGrant = 1'b0;
            held     = 1'b0;
            if (reqWrite)
               mem[reqAddr] = reqData;
            else
            begin
               rdPending = 1'b1;
               rdAddr    = reqAddr;
               dataWait  = $urandom_range(3, 0);
            end
         end
         if (rdPending)
         begin
            if (dataWait == 0)
            begin
               cpuDataValid = 1'b1;
               cpuReadData  = mem[rdAddr];
               rdPending    = 1'b0;
            end
            else
               dataWait--;
         end
         // a request that is waiting for its grant may not be withdrawn
         if (held)
            checkValue("cpuReq", lineW'(cpuReq), lineW'(1'b1));
         if (cpuReq)
         begin
            if (!held)
            begin
               held      = 1'b1;
               reqAddr   = cpuAddress;
               reqWrite  = cpuWrite;
               reqData   = cpuWriteData;
               grantWait = $urandom_range(3, 0);
            end
            else
            begin
               checkValue("cpuAddress", lineW'(cpuAddress), lineW'(reqAddr));
               checkValue("cpuWrite", lineW'(cpuWrite), lineW'(reqWrite));
               checkValue("cpuWriteData", cpuWriteData, reqData);
            end
            if (grantWait == 0)
               cpuGrant = 1'b1;
            else
               grantWait--;
         end
      end
   end

   ////////////////////////////////////////
   // client transactions
   ////////////////////////////////////////

   // one read or read-clear, with every response checked against the model
   task automatic readLine(input int lineAddr, input int start, input int size,
                           input logic clear);
      int              left;
      int              idx;
      int              n;
      int              waited;
      logic [busW-1:0] expData;
      // the line request ends at the line end or when the size runs out
      left = (size == 0) ? 64 : size;
      if (left > LineWords - start)
         left = LineWords - start;
      idx          = start;
      waited       = 0;
      supRead      = 1'b1;
      supWrite     = clear;
      supAddress   = {addrW'(lineAddr), idxW'(start)};
      supTotalSize = sizeW'(size);
      while (left > 0)
      begin
         @(negedge sysClk);
         waited++;
         if (waited > waitLimit)
            reportTimeout("a read response");
         if (readDataValid)
         begin
            n = (left >= 2) ? 2 : 1;
            expData = '0;
            expData[busW-1 -: wordW] = refMem[lineAddr][idx];
            if (n == 2)
               expData[wordW-1:0] = refMem[lineAddr][idx+1];
            checkValue("readData", lineW'(readData), lineW'(expData));
            checkValue("accessSize", lineW'(accessSize), lineW'(n));
            checkValue("accessComplete", lineW'(accessComplete), lineW'(left == n));
            idx    += n;
            left   -= n;
            waited  = 0;
         end
         else
            checkValue("accessComplete", lineW'(accessComplete), '0);
      end
      supRead  = 1'b0;
      supWrite = 1'b0;
      // read-clear zeroes the whole line, not just the words returned
      if (clear)
      begin
         for (int w = 0; w < LineWords; w++)
            refMem[lineAddr][w] = '0;
      end
      @(negedge sysClk);
   endtask

   // a burst of two-word write beats from start, then the wait for completion
   task automatic writeLine(input int lineAddr, input int start, input int size);
      int               left;
      int               idx;
      int               waited;
      logic [wordW-1:0] hi;
      logic [wordW-1:0] lo;
      left    = (size == 0) ? 64 : size;
      idx     = start;
      waited  = 0;
      supRead = 1'b0;
      while (left > 0 && idx < LineWords)
      begin
         hi           = $urandom();
         lo           = $urandom();
         supWrite     = 1'b1;
         supAddress   = {addrW'(lineAddr), idxW'(idx)};
         supTotalSize = sizeW'(left);
         supWriteData = {hi, lo};
         refMem[lineAddr][idx] = hi;
         // the low half only counts when a second word is left in the line
         if (left >= 2 && idx < LineWords - 1)
            refMem[lineAddr][idx+1] = lo;
         idx  += 2;
         left -= 2;
         @(negedge sysClk);
      end
      supWrite = 1'b0;
      while (!accessComplete)
      begin
         checkValue("readDataValid", lineW'(readDataValid), '0);
         @(negedge sysClk);
         waited++;
         if (waited > waitLimit)
            reportTimeout("write completion");
      end
      @(negedge sysClk);
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial
   begin : stimulus
      int lineAddr;
      int start;
      int size;
      void'($urandom(11));
      rstN         = 1'b0;
      supRead      = 1'b0;
      supWrite     = 1'b0;
      supAddress   = '0;
      supTotalSize = '0;
      supWriteData = '0;
      for (int l = 0; l < Depth; l++)
      begin
         for (int w = 0; w < LineWords; w++)
         begin
            refMem[l][w] = $urandom();
            mem[l][w*wordW +: wordW] = refMem[l][w];
         end
      end

      // ten cycles in reset and a few idle ones after it, all quiet
      for (int c = 0; c < 13; c++)
      begin
         @(negedge sysClk);
         checkValue("cpuReq", lineW'(cpuReq), '0);
         checkValue("readDataValid", lineW'(readDataValid), '0);
         checkValue("accessComplete", lineW'(accessComplete), '0);
         if (c == 9)
            rstN = 1'b1;
      end

      for (int t = 0; t < 16; t++)
         readLine($urandom_range(Depth - 1, 0), $urandom_range(LineWords - 1, 0),
                  randomSize(), 1'b0);

      // full writes, the first with a size of 0 that stands for 64 words
      for (int t = 0; t < 4; t++)
      begin
         lineAddr = $urandom_range(Depth - 1, 0);
         writeLine(lineAddr, 0, (t == 0) ? 0 : LineWords + $urandom_range(8, 0));
         readLine(lineAddr, 0, LineWords, 1'b0);
      end

      for (int t = 0; t < 6; t++)
      begin
         lineAddr = $urandom_range(Depth - 1, 0);
         writeLine(lineAddr, $urandom_range(LineWords - 2, 1), $urandom_range(2, 1));
         readLine(lineAddr, 0, LineWords, 1'b0);
      end

      for (int t = 0; t < 4; t++)
      begin
         lineAddr = $urandom_range(Depth - 1, 0);
         readLine(lineAddr, $urandom_range(LineWords - 1, 0), randomSize(), 1'b1);
         readLine(lineAddr, 0, LineWords, 1'b0);
      end

      // a random mix, then a sweep that reads back the whole memory
      for (int t = 0; t < 20; t++)
      begin
         lineAddr = $urandom_range(Depth - 1, 0);
         start    = $urandom_range(LineWords - 1, 0);
         size     = randomSize();
         case ($urandom_range(2, 0))
            0: readLine(lineAddr, start, size, 1'b0);
            1: readLine(lineAddr, start, size, 1'b1);
            default: writeLine(lineAddr, start, size);
         endcase
      end
      for (int l = 0; l < Depth; l++)
         readLine(l, 0, LineWords, 1'b0);

      $display("No errors");
      $finish;
   end

endmodule

/* project.f */
source/transPkg.sv
source/lineIf.sv
source/lineSequencer.sv
source/lineBuffer.sv
source/supResponder.sv
source/cepTransactor.sv
bench/transactorTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile the transactor and its testbench with Verilator, then run the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module transactorTb -f project.f &&
./obj_dir/VtransactorTb || exit 1
